// File: verilog/snake_pkg.sv
package snake_pkg;

    localparam int SEG_COUNT = 7;

    // Active low, bit index is the segment index
    typedef logic [SEG_COUNT-1:0] seg_t;
    typedef logic [2:0] pos_t;

    localparam pos_t SEG_A = 3'd0;
    localparam pos_t SEG_B = 3'd1;
    localparam pos_t SEG_C = 3'd2;
    localparam pos_t SEG_D = 3'd3;
    localparam pos_t SEG_E = 3'd4;
    localparam pos_t SEG_F = 3'd5;
    localparam pos_t SEG_G = 3'd6;

    localparam seg_t SEG_ALL_DARK = 7'b111_1111;
    localparam seg_t SEG_ONLY_G = 7'b011_1111;

    typedef enum logic [1:0] {RIGHT, LEFT, UP, DOWN} heading_t;

    typedef enum logic [1:0] {ST_INIT, ST_MOVE, ST_FALL} game_state_t;

    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } btn_t;

    typedef struct packed {
        logic init;
        logic move;
        logic fall;
    } status_t;

    localparam int DEBOUNCE_LEN = 4;
    localparam int SLOW_TICK_CYCLES = 32;
    localparam int BLINK_TICK_CYCLES = 16;
    localparam int INIT_TICKS = 3;
    localparam int FALL_END_TICKS = 1;

    // Prescaler and state tick counter widths
    typedef logic [$clog2(SLOW_TICK_CYCLES)-1:0] slow_cnt_t;
    typedef logic [$clog2(BLINK_TICK_CYCLES)-1:0] blink_cnt_t;
    typedef logic [1:0] tick_cnt_t;

endpackage

// File: verilog/button_conditioner.sv
`timescale 1ns/1ns

module button_conditioner (
    input  logic            clk,
    input  logic            rst,
    input  snake_pkg::btn_t btn,
    output snake_pkg::btn_t pulse
);

    snake_pkg::btn_t btn_sync;
    snake_pkg::btn_t [snake_pkg::DEBOUNCE_LEN-1:0] hist;
    snake_pkg::btn_t level;
    snake_pkg::btn_t level_d;

    // Stable only when every sample in the window is high
    always_comb begin
        level = '1;
        for (int i = 0; i < snake_pkg::DEBOUNCE_LEN; i++) begin
            level = level & hist[i];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_sync <= '0;
            hist <= '0;
            level_d <= '0;
            pulse <= '0;
        end else begin
            // Buttons are asynchronous, take one register stage first
            btn_sync <= btn;
            hist <= {hist[snake_pkg::DEBOUNCE_LEN-2:0], btn_sync};
            level_d <= level;
            pulse <= level & ~level_d;
        end
    end

    a_pulse_single : assert property (
        @(posedge clk) disable iff (rst)
        (pulse & $past(pulse)) == '0
    );

endmodule

// File: verilog/tick_gen.sv
`timescale 1ns/1ns

module tick_gen (
    input  logic clk,
    input  logic rst,
    output logic slow_tick,
    output logic blink_tick
);

    snake_pkg::slow_cnt_t slow_cnt;
    snake_pkg::blink_cnt_t blink_cnt;

    // Strobe in the cycle the counter sits at zero
    assign slow_tick = (slow_cnt == '0);
    assign blink_tick = (blink_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slow_cnt <= snake_pkg::slow_cnt_t'(snake_pkg::SLOW_TICK_CYCLES - 1);
            blink_cnt <= snake_pkg::blink_cnt_t'(snake_pkg::BLINK_TICK_CYCLES - 1);
        end else begin
            if (slow_tick) begin
                slow_cnt <= snake_pkg::slow_cnt_t'(snake_pkg::SLOW_TICK_CYCLES - 1);
            end else begin
                slow_cnt <= slow_cnt - 1'b1;
            end

            if (blink_tick) begin
                blink_cnt <= snake_pkg::blink_cnt_t'(snake_pkg::BLINK_TICK_CYCLES - 1);
            end else begin
                blink_cnt <= blink_cnt - 1'b1;
            end
        end
    end

endmodule

// File: verilog/game_ctrl.sv
`timescale 1ns/1ns

module game_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  snake_pkg::btn_t    pulse,
    input  logic               slow_tick,
    input  logic               blink_tick,
    input  logic               all_eaten,
    output snake_pkg::status_t status
);

    snake_pkg::game_state_t state;
    snake_pkg::game_state_t state_next;
    snake_pkg::tick_cnt_t tick_cnt;
    snake_pkg::tick_cnt_t tick_cnt_next;

    function automatic snake_pkg::status_t decode(snake_pkg::game_state_t st);
        snake_pkg::status_t s;
        s = '0;
        case (st)
            snake_pkg::ST_MOVE: s.move = 1'b1;
            snake_pkg::ST_FALL: s.fall = 1'b1;
            default: s.init = 1'b1;
        endcase
        return s;
    endfunction

    always_comb begin
        state_next = state;
        tick_cnt_next = tick_cnt;
        case (state)
            snake_pkg::ST_INIT: begin
                if (slow_tick) begin
                    if (tick_cnt == snake_pkg::tick_cnt_t'(snake_pkg::INIT_TICKS - 1)) begin
                        state_next = snake_pkg::ST_MOVE;
                        tick_cnt_next = '0;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            snake_pkg::ST_MOVE: begin
                if (pulse.down) begin
                    state_next = snake_pkg::ST_FALL;
                    tick_cnt_next = '0;
                end
            end
            snake_pkg::ST_FALL: begin
                // Blink ticks only count once the whole digit is eaten
                if (all_eaten && blink_tick) begin
                    if (tick_cnt == snake_pkg::tick_cnt_t'(snake_pkg::FALL_END_TICKS - 1)) begin
                        state_next = snake_pkg::ST_INIT;
                        tick_cnt_next = '0;
                    end else begin
                        tick_cnt_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: begin
                state_next = snake_pkg::ST_INIT;
                tick_cnt_next = '0;
            end
        endcase
    end

    // Status taken from the next state so it lands one cycle after the event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= snake_pkg::ST_INIT;
            tick_cnt <= '0;
            status <= decode(snake_pkg::ST_INIT);
        end else begin
            state <= state_next;
            tick_cnt <= tick_cnt_next;
            status <= decode(state_next);
        end
    end

    a_status_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot(status)
    );

endmodule

// File: verilog/segment_walker.sv
`timescale 1ns/1ns

module segment_walker (
    input  logic               clk,
    input  logic               rst,
    input  snake_pkg::btn_t    pulse,
    input  snake_pkg::status_t status,
    output snake_pkg::pos_t    pos,
    output snake_pkg::seg_t    eaten,
    output logic               all_eaten
);

    snake_pkg::heading_t heading;
    snake_pkg::heading_t heading_next;
    snake_pkg::pos_t pos_next;

    assign all_eaten = (eaten == '0);

    // Move rule, earlier button in each branch wins
    always_comb begin
        pos_next = pos;
        heading_next = heading;
        case (pos)
            snake_pkg::SEG_A: begin
                if (heading == snake_pkg::RIGHT && pulse.right) begin
                    pos_next = snake_pkg::SEG_B;
                    heading_next = snake_pkg::DOWN;
                end else if (heading == snake_pkg::LEFT && pulse.left) begin
                    pos_next = snake_pkg::SEG_F;
                    heading_next = snake_pkg::DOWN;
                end
            end
            snake_pkg::SEG_B: begin
                if (heading == snake_pkg::UP && pulse.left) begin
                    pos_next = snake_pkg::SEG_A;
                    heading_next = snake_pkg::LEFT;
                end else if (heading == snake_pkg::DOWN && pulse.right) begin
                    pos_next = snake_pkg::SEG_G;
                    heading_next = snake_pkg::LEFT;
                end else if (heading == snake_pkg::DOWN && pulse.up) begin
                    pos_next = snake_pkg::SEG_C;
                    heading_next = snake_pkg::DOWN;
                end
            end
            snake_pkg::SEG_C: begin
                if (heading == snake_pkg::UP && pulse.left) begin
                    pos_next = snake_pkg::SEG_G;
                    heading_next = snake_pkg::LEFT;
                end else if (heading == snake_pkg::UP && pulse.up) begin
                    pos_next = snake_pkg::SEG_B;
                    heading_next = snake_pkg::UP;
                end else if (heading == snake_pkg::DOWN && pulse.right) begin
                    pos_next = snake_pkg::SEG_D;
                    heading_next = snake_pkg::DOWN;
                end
            end
            snake_pkg::SEG_D: begin
                if (heading == snake_pkg::RIGHT && pulse.left) begin
                    pos_next = snake_pkg::SEG_C;
                    heading_next = snake_pkg::UP;
                end else if (heading == snake_pkg::LEFT && pulse.right) begin
                    pos_next = snake_pkg::SEG_E;
                    heading_next = snake_pkg::UP;
                end
            end
            snake_pkg::SEG_E: begin
                if (heading == snake_pkg::UP && pulse.right) begin
                    pos_next = snake_pkg::SEG_G;
                    heading_next = snake_pkg::RIGHT;
                end else if (heading == snake_pkg::UP && pulse.up) begin
                    pos_next = snake_pkg::SEG_F;
                    heading_next = snake_pkg::UP;
                end else if (heading == snake_pkg::DOWN && pulse.left) begin
                    pos_next = snake_pkg::SEG_D;
                    heading_next = snake_pkg::RIGHT;
                end
            end
            snake_pkg::SEG_F: begin
                if (heading == snake_pkg::UP && pulse.right) begin
                    pos_next = snake_pkg::SEG_A;
                    heading_next = snake_pkg::RIGHT;
                end else if (heading == snake_pkg::DOWN && pulse.left) begin
                    pos_next = snake_pkg::SEG_G;
                    heading_next = snake_pkg::RIGHT;
                end
            end
            snake_pkg::SEG_G: begin
                if (heading == snake_pkg::RIGHT && pulse.left) begin
                    pos_next = snake_pkg::SEG_B;
                    heading_next = snake_pkg::UP;
                end else if (heading == snake_pkg::RIGHT && pulse.right) begin
                    pos_next = snake_pkg::SEG_C;
                    heading_next = snake_pkg::DOWN;
                end else if (heading == snake_pkg::LEFT && pulse.left) begin
                    pos_next = snake_pkg::SEG_E;
                    heading_next = snake_pkg::DOWN;
                end else if (heading == snake_pkg::LEFT && pulse.right) begin
                    pos_next = snake_pkg::SEG_F;
                    heading_next = snake_pkg::UP;
                end
            end
            default: begin
                pos_next = snake_pkg::SEG_G;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos <= snake_pkg::SEG_G;
            heading <= snake_pkg::LEFT;
            eaten <= snake_pkg::SEG_ALL_DARK;
        end else if (status.init) begin
            pos <= snake_pkg::SEG_G;
            heading <= snake_pkg::LEFT;
            eaten <= snake_pkg::SEG_ALL_DARK;
        end else begin
            pos <= pos_next;
            heading <= heading_next;
            // Every segment visited while falling stays lit
            if (status.fall) begin
                eaten[pos] <= 1'b0;
            end
        end
    end

    a_pos_range : assert property (
        @(posedge clk) disable iff (rst)
        pos <= snake_pkg::SEG_G
    );

endmodule

// File: verilog/display_driver.sv
`timescale 1ns/1ns

module display_driver (
    input  logic               clk,
    input  logic               rst,
    input  snake_pkg::status_t status,
    input  snake_pkg::pos_t    pos,
    input  snake_pkg::seg_t    eaten,
    input  logic               blink_tick,
    output snake_pkg::seg_t    seg
);

    logic phase;
    snake_pkg::seg_t seg_next;

    always_comb begin
        seg_next = snake_pkg::SEG_ALL_DARK;
        if (status.fall) begin
            seg_next = eaten;
            // Head is lit in phase 1, dark in phase 0
            seg_next[pos] = ~phase;
        end else if (status.move) begin
            seg_next[pos] = 1'b0;
        end else begin
            seg_next = snake_pkg::SEG_ONLY_G;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 1'b0;
            seg <= snake_pkg::SEG_ONLY_G;
        end else begin
            if (!status.fall) begin
                phase <= 1'b0;
            end else if (blink_tick) begin
                phase <= ~phase;
            end
            seg <= seg_next;
        end
    end

endmodule

// File: verilog/snake_top.sv
`timescale 1ns/1ns

module snake_top (
    input  logic               clk,
    input  logic               rst,
    input  snake_pkg::btn_t    btn,
    output snake_pkg::seg_t    seg,
    output snake_pkg::status_t status
);

    snake_pkg::btn_t pulse;
    logic slow_tick;
    logic blink_tick;
    snake_pkg::pos_t pos;
    snake_pkg::seg_t eaten;
    logic all_eaten;

    button_conditioner i_buttons (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn),
        .pulse (pulse)
    );

    tick_gen i_ticks (
        .clk        (clk),
        .rst        (rst),
        .slow_tick  (slow_tick),
        .blink_tick (blink_tick)
    );

    game_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .pulse      (pulse),
        .slow_tick  (slow_tick),
        .blink_tick (blink_tick),
        .all_eaten  (all_eaten),
        .status     (status)
    );

    segment_walker i_walker (
        .clk       (clk),
        .rst       (rst),
        .pulse     (pulse),
        .status    (status),
        .pos       (pos),
        .eaten     (eaten),
        .all_eaten (all_eaten)
    );

    display_driver i_display (
        .clk        (clk),
        .rst        (rst),
        .status     (status),
        .pos        (pos),
        .eaten      (eaten),
        .blink_tick (blink_tick),
        .seg        (seg)
    );

endmodule

// File: tests/tb_moves.svh
`ifndef TB_MOVES_SVH
`define TB_MOVES_SVH

// Each row holds the buttons, the hold length in cycles, the expected head segment
// and the expected status once the press has settled

typedef struct packed {
    snake_pkg::btn_t btn;
    logic [7:0] hold;
    snake_pkg::pos_t exp_pos;
    snake_pkg::status_t exp_status;
} move_row_t;

localparam snake_pkg::btn_t BTN_RIGHT = 4'b1000;
localparam snake_pkg::btn_t BTN_LEFT = 4'b0100;
localparam snake_pkg::btn_t BTN_UP = 4'b0010;
localparam snake_pkg::btn_t BTN_DOWN = 4'b0001;

localparam snake_pkg::status_t ST_IN_INIT = 3'b100;
localparam snake_pkg::status_t ST_IN_MOVE = 3'b010;
localparam snake_pkg::status_t ST_IN_FALL = 3'b001;

move_row_t moves[$];

task automatic add_row(snake_pkg::btn_t buttons, int hold, snake_pkg::pos_t exp_pos,
                       snake_pkg::status_t exp_status);
    move_row_t row;
    row.btn = buttons;
    row.hold = 8'(hold);
    row.exp_pos = exp_pos;
    row.exp_status = exp_status;
    moves.push_back(row);
endtask

task automatic load_moves();
    // Move round from G back to G with ignored and bounced presses
    add_row(BTN_RIGHT, 6, snake_pkg::SEG_F, ST_IN_MOVE);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_F, ST_IN_MOVE);
    add_row(BTN_RIGHT, 2, snake_pkg::SEG_F, ST_IN_MOVE);
    add_row(BTN_RIGHT, 3, snake_pkg::SEG_F, ST_IN_MOVE);
    add_row(BTN_RIGHT, 20, snake_pkg::SEG_A, ST_IN_MOVE);
    add_row(BTN_RIGHT, 6, snake_pkg::SEG_B, ST_IN_MOVE);
    // Right wins over up when both are pressed
    add_row(BTN_RIGHT | BTN_UP, 6, snake_pkg::SEG_G, ST_IN_MOVE);
    // Fall path that eats all seven segments
    add_row(BTN_DOWN, 6, snake_pkg::SEG_G, ST_IN_FALL);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_E, ST_IN_FALL);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_D, ST_IN_FALL);
    add_row(BTN_UP, 6, snake_pkg::SEG_D, ST_IN_FALL);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_C, ST_IN_FALL);
    add_row(BTN_UP, 6, snake_pkg::SEG_B, ST_IN_FALL);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_A, ST_IN_FALL);
    add_row(BTN_LEFT, 6, snake_pkg::SEG_F, ST_IN_INIT);
    // Walker starts over from G heading left
    add_row(BTN_RIGHT, 6, snake_pkg::SEG_F, ST_IN_MOVE);
endtask

`endif

// File: tests/tb_snake.sv
`timescale 1ns/1ns

module tb_snake;

    `include "tb_moves.svh"

    localparam int GAP_BASE = snake_pkg::DEBOUNCE_LEN + 4;
    localparam int INIT_BOUND = snake_pkg::INIT_TICKS * snake_pkg::SLOW_TICK_CYCLES + 2;
    localparam int FALL_BOUND = snake_pkg::FALL_END_TICKS * snake_pkg::BLINK_TICK_CYCLES + 1;
    localparam int WATCH_CYCLES = 2 * snake_pkg::BLINK_TICK_CYCLES;

    logic clk;
    logic rst;
    snake_pkg::btn_t btn;
    snake_pkg::seg_t seg;
    snake_pkg::status_t status;

    logic [31:0] lfsr;
    int cycle_count;
    int cycle_limit;
    snake_pkg::seg_t exp_eaten;

    snake_top i_dut (
        .clk    (clk),
        .rst    (rst),
        .btn    (btn),
        .seg    (seg),
        .status (status)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    function automatic logic [31:0] galois_step(logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    task automatic random_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr = galois_step(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // Active low, only segment p lit
    function automatic snake_pkg::seg_t only_lit(snake_pkg::pos_t p);
        snake_pkg::seg_t s;
        s = snake_pkg::SEG_ALL_DARK;
        s[p] = 1'b0;
        return s;
    endfunction

    function automatic int run_length();
        int total;
        total = 0;
        foreach (moves[i]) begin
            total += int'(moves[i].hold) + GAP_BASE + 7 + WATCH_CYCLES;
        end
        return 2 * total + 2 * INIT_BOUND + FALL_BOUND + 5;
    endfunction

    task automatic wait_status(snake_pkg::status_t target, int bound, string what);
        int waited;
        waited = 0;
        while (status !== target && waited < bound) begin
            @(negedge clk);
            waited++;
        end
        if (status !== target) begin
            $display("Status %s never arrived within %0d cycles", what, bound);
            abort_run();
        end
    endtask

    // Called on a falling edge, returns on one
    task automatic press(snake_pkg::btn_t buttons, int hold);
        int extra;
        btn = buttons;
        repeat (hold) @(negedge clk);
        btn = '0;
        random_bits(3, extra);
        repeat (GAP_BASE + extra) @(negedge clk);
    endtask

    task automatic watch_blink(snake_pkg::pos_t head);
        snake_pkg::seg_t head_mask;
        logic seen_lit;
        logic seen_dark;
        head_mask = ~only_lit(head);
        seen_lit = 1'b0;
        seen_dark = 1'b0;
        repeat (WATCH_CYCLES) begin
            check_value("seg eaten", seg | head_mask, exp_eaten | head_mask);
            if (seg[head] == 1'b0) begin
                seen_lit = 1'b1;
            end else begin
                seen_dark = 1'b1;
            end
            @(negedge clk);
        end
        check_value("head seen lit", seen_lit, 1);
        check_value("head seen dark", seen_dark, 1);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        btn = '0;
        lfsr = 32'hc882;
        cycle_count = 0;
        exp_eaten = snake_pkg::SEG_ALL_DARK;
        load_moves();
        cycle_limit = run_length();

        repeat (5) @(negedge clk);
        rst = 1'b0;
        check_value("status", status, ST_IN_INIT);
        check_value("seg", seg, only_lit(snake_pkg::SEG_G));
        wait_status(ST_IN_MOVE, INIT_BOUND, "move after reset");

        foreach (moves[i]) begin
            press(moves[i].btn, moves[i].hold);
            if (moves[i].exp_status == ST_IN_INIT) begin
                // Last segment eaten, game returns to init
                wait_status(ST_IN_INIT, FALL_BOUND, "init after fall");
                @(negedge clk);
                check_value("seg", seg, only_lit(snake_pkg::SEG_G));
                exp_eaten = snake_pkg::SEG_ALL_DARK;
                wait_status(ST_IN_MOVE, INIT_BOUND, "move after fall");
            end else begin
                check_value("status", status, moves[i].exp_status);
                if (moves[i].exp_status == ST_IN_FALL) begin
                    exp_eaten[moves[i].exp_pos] = 1'b0;
                    watch_blink(moves[i].exp_pos);
                end else begin
                    check_value("seg", seg, only_lit(moves[i].exp_pos));
                end
            end
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: sim.f
+incdir+tests
verilog/snake_pkg.sv
verilog/button_conditioner.sv
verilog/tick_gen.sv
verilog/game_ctrl.sv
verilog/segment_walker.sv
verilog/display_driver.sv
verilog/snake_top.sv
tests/tb_snake.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench, exit status follows the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_snake -f sim.f -o tb_snake

./obj_dir/tb_snake
